// File: Makefile
# Verilator lint and simulation of the pad path

VERILATOR ?= verilator
FILELIST  ?= verilog.f
TB_TOP    ?= pad_top_tb
RTL_TOP   ?= pad_top
INC_DIR   ?= logic
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 2
EXTRA     ?=

PASS_MSG := Simulation PASSED
RTL_SRCS := $(filter logic/%.sv,$(shell cat $(FILELIST)))
SIM_BIN  := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only +incdir+$(INC_DIR) --top-module $(RTL_TOP) \
	  $(RTL_SRCS) $(EXTRA)
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) \
	  --top-module $(TB_TOP) $(EXTRA)

sim:
	$(VERILATOR) --binary --timing --assert -j $(JOBS) -f $(FILELIST) \
	  --top-module $(TB_TOP) -Mdir $(OBJ_DIR) $(EXTRA)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "pass message missing in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: logic/button_merge.sv
/*
  button merge
  keeps the host override bytes of both players and ORs each one
  with that player's pad byte, one cycle late
*/
`default_nettype none
`include "pad_cfg.svh"

module button_merge (
  input  logic                     i_clk,
  input  logic                     i_sys_resetn,
  input  host_bus_pkg::host_wr_t   i_host_wr,
  input  pad_types_pkg::pad_pair_t i_pad,
  output pad_types_pkg::pad_pair_t o_merged
);
  import pad_types_pkg::*;
  import host_bus_pkg::*;

  pad_pair_t override;  // host written buttons

  // register decode
  always_ff @(posedge i_clk) begin
    if (!i_sys_resetn) begin
      override <= '0;
    end else if (i_host_wr.stb) begin
      case (i_host_wr.addr)
        REG_BTN1: override[0] <= i_host_wr.data;
        REG_BTN2: override[1] <= i_host_wr.data;
        default: ;  // not ours
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_sys_resetn) begin
      o_merged <= '0;
    end else begin
      for (int p = 0; p < `PAD_PLAYERS; p++) begin
        o_merged[p] <= i_pad[p] | override[p];
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/host_bus_pkg.sv
/*
  host and CPU bus types
  register writes from the host and the CPU joypad port signals
*/
`default_nettype none
`include "pad_cfg.svh"

package host_bus_pkg;

  typedef enum logic [7:0] {
    REG_BTN1 = `REG_BTN1_ADDR,
    REG_BTN2 = `REG_BTN2_ADDR
  } host_reg_addr_e;

  // single-cycle register write
  typedef struct packed {
    logic           stb;
    host_reg_addr_e addr;
    logic [7:0]     data;
  } host_wr_t;

  // CPU side of the joypad registers
  typedef struct packed {
    logic                    strobe;  // load while high
    logic [`PAD_PLAYERS-1:0] clk;     // one read clock per player
  } joy_cpu_t;

endpackage

`default_nettype wire

// File: logic/joypad_port.sv
/*
  CPU joypad port
  per-player shift registers as the console CPU sees them, loaded
  while strobe is high and shifted on falling edges of the read clock
*/
`default_nettype none

module joypad_port (
  input  logic                     i_clk,
  input  logic                     i_sys_resetn,
  input  pad_types_pkg::pad_pair_t i_merged,
  input  host_bus_pkg::joy_cpu_t   i_joy,
  output logic [1:0]               o_joy_data
);
  import pad_types_pkg::*;

  localparam int NUM_P = $bits(o_joy_data);

  pad_pair_t        joy_bits;
  logic [NUM_P-1:0] last_clk;  // read clocks one cycle ago
  logic [NUM_P-1:0] clk_fall;

  assign clk_fall = last_clk & ~i_joy.clk;

  always_ff @(posedge i_clk) begin
    if (!i_sys_resetn) begin
      last_clk <= '0;
    end else begin
      last_clk <= i_joy.clk;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_sys_resetn) begin
      joy_bits <= '0;
    end else begin
      for (int p = 0; p < NUM_P; p++) begin
        if (i_joy.strobe) begin
          joy_bits[p] <= i_merged[p];  // strobe wins over shifting
        end else if (clk_fall[p]) begin
          joy_bits[p] <= {1'b0, joy_bits[p][7:1]};  // zeros after 8 reads
        end
      end
    end
  end

  // serial bit seen by the CPU
  always_comb begin
    for (int p = 0; p < NUM_P; p++) begin
      o_joy_data[p] = joy_bits[p][0];
    end
  end

endmodule

`default_nettype wire

// File: logic/nes_pad_reader.sv
/*
  NES pad reader
  polls one classic pad over latch, clock and data once per poll
  period and keeps the last complete button byte
*/
`default_nettype none
`include "pad_cfg.svh"

module nes_pad_reader (
  input  logic                        i_clk,
  input  logic                        i_sys_resetn,
  input  logic                        i_pad_data,   // active low
  output logic                        o_pad_latch,
  output logic                        o_pad_clk,
  output pad_types_pkg::pad_buttons_t o_buttons
);
  import pad_types_pkg::*;

  localparam int HALF_W = $clog2(2 * `PAD_HALF_CYCLES);
  localparam int POLL_W = $clog2(`PAD_POLL_CYCLES);
  localparam logic [HALF_W-1:0] HALF_LAST  = HALF_W'(`PAD_HALF_CYCLES - 1);
  localparam logic [HALF_W-1:0] LATCH_LAST = HALF_W'(2 * `PAD_HALF_CYCLES - 1);
  localparam logic [POLL_W-1:0] POLL_LAST  = POLL_W'(`PAD_POLL_CYCLES - 1);

  pad_rd_state_e     state;
  logic [HALF_W-1:0] half_cnt;
  logic [POLL_W-1:0] poll_cnt;
  logic [2:0]        bit_idx;     // clock slots done
  pad_buttons_t      shift_byte;  // bits of the running poll
  logic              sample;

  // free running poll period
  always_ff @(posedge i_clk) begin
    if (!i_sys_resetn) begin
      poll_cnt <= '0;
    end else if (poll_cnt == POLL_LAST) begin
      poll_cnt <= '0;
    end else begin
      poll_cnt <= poll_cnt + 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_sys_resetn) begin
      state     <= RD_WAIT;
      half_cnt  <= '0;
      bit_idx   <= '0;
      o_buttons <= '0;
    end else begin
      case (state)
        RD_WAIT: begin
          half_cnt <= '0;
          bit_idx  <= '0;
          if (poll_cnt == POLL_LAST) state <= RD_LATCH;
        end
        RD_LATCH: begin
          if (half_cnt == LATCH_LAST) begin
            half_cnt <= '0;
            state    <= RD_CLK_LOW;
          end else begin
            half_cnt <= half_cnt + 1'b1;
          end
        end
        RD_CLK_LOW: begin
          if (half_cnt == HALF_LAST) begin
            half_cnt <= '0;
            state    <= RD_CLK_HIGH;
          end else begin
            half_cnt <= half_cnt + 1'b1;
          end
        end
        RD_CLK_HIGH: begin
          if (half_cnt == HALF_LAST) begin
            half_cnt <= '0;
            if (bit_idx == 3'd7) begin
              state     <= RD_WAIT;
              o_buttons <= shift_byte;  // slot 8 closes the poll
            end else begin
              bit_idx <= bit_idx + 1'b1;
              state   <= RD_CLK_LOW;
            end
          end else begin
            half_cnt <= half_cnt + 1'b1;
          end
        end
        default: state <= RD_WAIT;
      endcase
    end
  end

  // bit a at end of latch then at end of each high phase of slots 1 to 7
  assign sample = (state == RD_LATCH && half_cnt == LATCH_LAST) ||
                  (state == RD_CLK_HIGH && half_cnt == HALF_LAST && bit_idx != 3'd7);

  always_ff @(posedge i_clk) begin
    if (sample) shift_byte <= {~i_pad_data, shift_byte[7:1]};  // lsb first
  end

  assign o_pad_latch = (state == RD_LATCH);
  assign o_pad_clk   = (state == RD_CLK_HIGH);

endmodule

`default_nettype wire

// File: logic/pad_cfg.svh
/*
  pad path configuration
  timing of the NES pad pins, the player count and the host
  override register addresses
*/
`ifndef PAD_CFG_SVH
`define PAD_CFG_SVH

// clock cycles per half bit on latch and pad clock
`define PAD_HALF_CYCLES 4

// cycles from one poll start to the next which must exceed 18 half bits
`define PAD_POLL_CYCLES 200

`define PAD_PLAYERS 2

// host override registers
`define REG_BTN1_ADDR 8'h40  // player 1
`define REG_BTN2_ADDR 8'h41  // player 2

`endif

// File: logic/pad_top.sv
/*
  pad path top level
  two NES pad readers, host override merge and the CPU joypad port
*/
`default_nettype none
`include "pad_cfg.svh"

module pad_top (
  input  logic                    clk,
  input  logic                    sys_resetn,
  input  host_bus_pkg::host_wr_t  i_host_wr,
  input  host_bus_pkg::joy_cpu_t  i_joy,
  output logic [`PAD_PLAYERS-1:0] o_joy_data,
  output logic [`PAD_PLAYERS-1:0] o_pad_latch,
  output logic [`PAD_PLAYERS-1:0] o_pad_clk,
  input  logic [`PAD_PLAYERS-1:0] i_pad_data
);
  import pad_types_pkg::*;

  pad_pair_t pad_btn;  // decoded pad bytes
  pad_pair_t merged;   // pad OR override

  nes_pad_reader u_reader1 (
    .i_clk        (clk),
    .i_sys_resetn (sys_resetn),
    .i_pad_data   (i_pad_data[0]),
    .o_pad_latch  (o_pad_latch[0]),
    .o_pad_clk    (o_pad_clk[0]),
    .o_buttons    (pad_btn[0])
  );

  nes_pad_reader u_reader2 (
    .i_clk        (clk),
    .i_sys_resetn (sys_resetn),
    .i_pad_data   (i_pad_data[1]),
    .o_pad_latch  (o_pad_latch[1]),
    .o_pad_clk    (o_pad_clk[1]),
    .o_buttons    (pad_btn[1])
  );

  button_merge u_merge (
    .i_clk        (clk),
    .i_sys_resetn (sys_resetn),
    .i_host_wr    (i_host_wr),
    .i_pad        (pad_btn),
    .o_merged     (merged)
  );

  joypad_port u_joypad (
    .i_clk        (clk),
    .i_sys_resetn (sys_resetn),
    .i_merged     (merged),
    .i_joy        (i_joy),
    .o_joy_data   (o_joy_data)
  );

endmodule

`default_nettype wire

// File: logic/pad_types_pkg.sv
/*
  pad button types
  NES button byte, per-player button arrays and reader states
*/
`default_nettype none
`include "pad_cfg.svh"

package pad_types_pkg;

  // NES button byte where 1 means pressed
  typedef struct packed {
    logic right;
    logic left;
    logic down;
    logic up;
    logic start;
    logic select;
    logic b;
    logic a;       // bit 0 and first on the wire
  } pad_buttons_t;

  // one byte per player with index 0 as player 1
  typedef pad_buttons_t [`PAD_PLAYERS-1:0] pad_pair_t;

  typedef enum logic [1:0] {
    RD_WAIT     = 2'd0,  // idle between polls
    RD_LATCH    = 2'd1,
    RD_CLK_LOW  = 2'd2,
    RD_CLK_HIGH = 2'd3
  } pad_rd_state_e;

endpackage

`default_nettype wire

// File: tests/pad_assert.sv
/*
  pad path assertions
  pad pin protocol and joypad output checks, bound into pad_top
*/
`default_nettype none
`include "pad_cfg.svh"

module pad_assert (
  input logic                    clk,
  input logic                    sys_resetn,
  input logic [`PAD_PLAYERS-1:0] i_pad_latch,
  input logic [`PAD_PLAYERS-1:0] i_pad_clk,
  input logic [`PAD_PLAYERS-1:0] i_joy_data
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int LATCH_CYC = 2 * `PAD_HALF_CYCLES;

  logic in_reset_q;  // reset seen on the previous edge

  always_ff @(posedge clk) begin
    in_reset_q <= !sys_resetn;
  end

  a_joy_reset: assert property (@(posedge clk) (!sys_resetn && in_reset_q) |-> i_joy_data == '0)
    else $error("joypad data not 0 during reset");

  for (genvar p = 0; p < `PAD_PLAYERS; p++) begin : g_pad
    int unsigned latch_len;  // cycles latch has been high

    always_ff @(posedge clk) begin
      if (!sys_resetn) begin
        latch_len <= 0;
      end else if (i_pad_latch[p]) begin
        latch_len <= latch_len + 1;
      end else begin
        latch_len <= 0;
      end
    end

    a_no_overlap: assert property (@(posedge clk) disable iff (!sys_resetn)
        !(i_pad_latch[p] && i_pad_clk[p]))
      else $error("latch and pad clock high together on pad %0d", p);

    a_latch_len: assert property (@(posedge clk) disable iff (!sys_resetn)
        $fell(i_pad_latch[p]) |-> latch_len == LATCH_CYC)
      else $error("latch pulse on pad %0d lasted %0d cycles", p, latch_len);
  end

endmodule

`default_nettype wire

// File: tests/pad_top_tb.sv
/*
  pad path testbench
  NES pad models, host override writes and CPU joypad reads,
  checked against the OR of pad and override bytes
*/
`default_nettype none
`include "pad_cfg.svh"

module pad_top_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import pad_types_pkg::*;
  import host_bus_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int NUM_TESTS  = 5;
  localparam int POLL_NS    = `PAD_POLL_CYCLES * CLK_PERIOD;

  typedef struct packed {
    logic [7:0] expected;
    logic [7:0] actual;
  } check_t;

  logic                    clk;
  logic                    sys_resetn;
  host_wr_t                host_wr;
  joy_cpu_t                joy;
  logic [`PAD_PLAYERS-1:0] joy_data;
  logic [`PAD_PLAYERS-1:0] pad_latch;
  logic [`PAD_PLAYERS-1:0] pad_clk;
  logic [`PAD_PLAYERS-1:0] pad_data;

  pad_pair_t               pad_held;  // buttons held on each pad model
  pad_pair_t               ovr_held;  // override bytes as the host wrote them
  logic [7:0]              pad_sr [`PAD_PLAYERS] = '{default: '0};
  logic [`PAD_PLAYERS-1:0] pad_clk_q = '0;

  check_t      check_q[$];
  string       name_q[$];
  int          n_pushed;
  int          n_done;
  int          n_errors;
  int          test_errors;
  int          n_tests;
  logic [31:0] rnd;

  pad_top DUT (
    .clk         (clk),
    .sys_resetn  (sys_resetn),
    .i_host_wr   (host_wr),
    .i_joy       (joy),
    .o_joy_data  (joy_data),
    .o_pad_latch (pad_latch),
    .o_pad_clk   (pad_clk),
    .i_pad_data  (pad_data)
  );

  bind pad_top pad_assert u_assert (
    .clk         (clk),
    .sys_resetn  (sys_resetn),
    .i_pad_latch (o_pad_latch),
    .i_pad_clk   (o_pad_clk),
    .i_joy_data  (o_joy_data)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // 4021 style shifter as the pad model of each player
  always @(posedge clk) begin
    for (int p = 0; p < `PAD_PLAYERS; p++) begin
      if (pad_latch[p]) begin
        pad_sr[p] <= pad_held[p];  // parallel load while latched
      end else if (pad_clk[p] && !pad_clk_q[p]) begin
        pad_sr[p] <= {1'b0, pad_sr[p][7:1]};
      end
      pad_clk_q[p] <= pad_clk[p];
    end
  end

  always_comb begin
    for (int p = 0; p < `PAD_PLAYERS; p++) begin
      pad_data[p] = ~pad_sr[p][0];  // pressed pulls the line low
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // what the CPU should read for one player
  function automatic logic [7:0] expected_btn(input logic [7:0] pad, input logic [7:0] ovr);
    return pad | ovr;
  endfunction

  task automatic wait_polls(input int n);
    repeat (n * `PAD_POLL_CYCLES) @(posedge clk);
  endtask

  task automatic set_pads(input logic [7:0] b1, input logic [7:0] b2);
    @(posedge clk);
    pad_held[0] <= b1;
    pad_held[1] <= b2;
    wait_polls(3);  // covers the two poll worst case
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
    @(posedge clk);
    host_wr.stb  <= 1'b1;
    host_wr.addr <= host_reg_addr_e'(addr);
    host_wr.data <= data;
    @(posedge clk);
    host_wr.stb <= 1'b0;
    if (addr == `REG_BTN1_ADDR) begin
      ovr_held[0] = data;
    end else if (addr == `REG_BTN2_ADDR) begin
      ovr_held[1] = data;
    end
  endtask

  // optional strobe then 8 read clocks of 2 cycles high and 2 low
  task automatic read_joy(input int p, input bit do_strobe, output logic [7:0] val);
    if (do_strobe) begin
      @(posedge clk);
      joy.strobe <= 1'b1;
      repeat (2) @(posedge clk);
      joy.strobe <= 1'b0;
    end
    for (int i = 0; i < 8; i++) begin
      @(posedge clk);
      joy.clk[p] <= 1'b1;
      @(posedge clk);
      @(negedge clk);
      val[i] = joy_data[p];  // sampled before the falling edge
      @(posedge clk);
      joy.clk[p] <= 1'b0;
      @(posedge clk);
    end
  endtask

  task automatic push_check(input string name, input logic [7:0] exp, input logic [7:0] act);
    name_q.push_back(name);
    check_q.push_back('{expected: exp, actual: act});
    n_pushed++;
  endtask

  task automatic check_read(input string name, input int p);
    logic [7:0] got;
    read_joy(p, 1'b1, got);
    push_check(name, expected_btn(pad_held[p], ovr_held[p]), got);
  endtask

  task automatic end_test(input string name);
    wait (n_done == n_pushed);
    n_tests++;
    if (test_errors == 0) begin
      $display("test %0d %s: pass", n_tests, name);
    end else begin
      $display("test %0d %s: %0d errors", n_tests, name, test_errors);
    end
    test_errors = 0;
  endtask

  always begin : compare
    check_t c;
    string  nm;
    wait (n_done != n_pushed);
    nm = name_q.pop_front();
    c  = check_q.pop_front();
    if (c.actual !== c.expected) begin
      $display("Error %s: expected %h, actual %h", nm, c.expected, c.actual);
      n_errors++;
      test_errors++;
    end
    n_done++;
  end

  initial begin : watchdog
    #(NUM_TESTS * 40 * POLL_NS);
    $display("watchdog: tests did not finish within %0d ns", NUM_TESTS * 40 * POLL_NS);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin : main
    logic [7:0] got;
    sys_resetn  = 1'b0;
    host_wr     = '0;
    joy         = '0;
    pad_held    = '0;
    ovr_held    = '0;
    n_pushed    = 0;
    n_done      = 0;
    n_errors    = 0;
    test_errors = 0;
    n_tests     = 0;
    rnd         = 32'hc85a_5224;
    repeat (10) @(posedge clk);
    sys_resetn <= 1'b1;

    wait_polls(3);  // pads released and no writes yet
    check_read("idle p1", 0);
    check_read("idle p2", 1);
    end_test("reset_idle");

    set_pads(8'h81, 8'h3c);
    check_read("pad p1", 0);
    check_read("pad p2", 1);
    end_test("pad_bytes");

    set_pads(8'h01, 8'h3c);
    write_reg(`REG_BTN1_ADDR, 8'h10);
    check_read("override p1", 0);
    check_read("override p2", 1);
    write_reg(8'h35, 8'hff);  // not a button register
    check_read("foreign addr p1", 0);
    check_read("foreign addr p2", 1);
    end_test("override");

    read_joy(0, 1'b1, got);
    push_check("shift full", expected_btn(pad_held[0], ovr_held[0]), got);
    read_joy(0, 1'b0, got);
    push_check("shift empty", 8'h00, got);
    read_joy(0, 1'b1, got);
    push_check("restrobe", expected_btn(pad_held[0], ovr_held[0]), got);
    end_test("shift_past_8");

    for (int r = 0; r < 20; r++) begin
      rnd = xorshift32(rnd);
      write_reg(`REG_BTN1_ADDR, rnd[7:0]);
      write_reg(`REG_BTN2_ADDR, rnd[15:8]);
      set_pads(rnd[23:16], rnd[31:24]);
      check_read("random p1", 0);
      check_read("random p2", 1);
    end
    end_test("random");

    $display("tests %0d, checks %0d, errors %0d", n_tests, n_done, n_errors);
    if (n_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+logic
logic/pad_types_pkg.sv
logic/host_bus_pkg.sv
logic/nes_pad_reader.sv
logic/button_merge.sv
logic/joypad_port.sv
logic/pad_top.sv
tests/pad_assert.sv
tests/pad_top_tb.sv
